//--- src/isaPkg.sv
package isaPkg;

    typedef logic [4:0]  regAddrT;
    typedef logic [31:0] instrT;

    // major opcodes
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;

    localparam logic [2:0] F3Add  = 3'b000;  // also SUB, MUL
    localparam logic [2:0] F3Slt  = 3'b010;
    localparam logic [2:0] F3Sltu = 3'b011;
    localparam logic [2:0] F3Xor  = 3'b100;
    localparam logic [2:0] F3Or   = 3'b110;
    localparam logic [2:0] F3And  = 3'b111;
    localparam logic [2:0] F3Beq  = 3'b000;
    localparam logic [2:0] F3Bne  = 3'b001;
    localparam logic [2:0] F3Blt  = 3'b100;
    localparam logic [2:0] F3Bge  = 3'b101;
    localparam logic [2:0] F3Bltu = 3'b110;
    localparam logic [2:0] F3Bgeu = 3'b111;

    localparam logic [6:0] F7Sub    = 7'b0100000;
    localparam logic [6:0] F7MulDiv = 7'b0000001;

    // field positions (lsb)
    localparam int OpLsb  = 0;
    localparam int RdLsb  = 7;
    localparam int F3Lsb  = 12;
    localparam int Rs1Lsb = 15;
    localparam int Rs2Lsb = 20;
    localparam int F7Lsb  = 25;

endpackage

//--- src/pipePkg.sv
package pipePkg;

    // operation selected in EXE
    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSltu,
        AluPassB,  // lui
        AluLink,   // jal, pc + 4
        AluMul
    } aluOpT;

    localparam int InstrBytes = 4;                // pc step
    localparam isaPkg::instrT NopInstr = '0;      // opcode 0 decodes as bubble

endpackage

//--- src/mulUnit.sv
`timescale 1ns/1ps

module mulUnit #(
    parameter int Xlen = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic [Xlen-1:0] a,
    input  logic [Xlen-1:0] b,
    output logic [Xlen-1:0] product,
    output logic            done
);

    localparam int CntW = $clog2(Xlen + 1);

    logic            running;
    logic [CntW-1:0] count;
    logic [Xlen-1:0] mcand;
    logic [Xlen-1:0] mplier;
    logic [Xlen-1:0] acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running <= 1'b1;
            count   <= '0;
        end else if (done) begin
            running <= 1'b0;
        end else if (running) begin
            count <= count + 1'b1;
        end
    end

    // one multiplier bit per cycle, low half wraps for signed operands too
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (running && !done) begin
            if (mplier[0]) acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign done    = running && (count == CntW'(Xlen));
    assign product = acc;

endmodule

//--- src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
    parameter int              Xlen   = 64,
    parameter logic [Xlen-1:0] PcInit = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetchOk,
    input  isaPkg::instrT   fetchData,
    input  logic            hold,
    input  logic            jalTaken,
    input  logic            branchTaken,
    input  logic [Xlen-1:0] branchTarget,
    input  logic [Xlen-1:0] ifImm,
    output logic [Xlen-1:0] fetchAddr,
    output logic [Xlen-1:0] ifPc,
    output isaPkg::instrT   ifInstr
);

    logic [Xlen-1:0] pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= PcInit;
        end else if (branchTaken) begin
            pc <= branchTarget;  // EXE redirect wins
        end else if (!hold) begin
            if (jalTaken) begin
                pc <= pc + ifImm;
            end else if (fetchOk) begin
                pc <= pc + Xlen'(pipePkg::InstrBytes);
            end
        end
    end

    assign fetchAddr = pc;
    assign ifPc      = pc;

    // squashed, missing or held words become bubbles
    assign ifInstr = (fetchOk && !hold && !branchTaken) ? fetchData : pipePkg::NopInstr;

endmodule

//--- src/decoder.sv
`timescale 1ns/1ps

module decoder #(
    parameter int Xlen = 64
) (
    input  isaPkg::instrT   ifInstr,
    input  logic [Xlen-1:0] ifPc,
    output logic            regWrite,
    output logic            aluSrcImm,
    output logic            useRs1,
    output logic            usePc,
    output logic            isBranch,
    output logic            isMul,
    output logic            jalTaken,
    output pipePkg::aluOpT  aluOp,
    output logic [Xlen-1:0] imm
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic           aligned;
    logic           f3Known;
    pipePkg::aluOpT f3Op;

    assign opcode  = ifInstr[isaPkg::OpLsb +: 7];
    assign funct3  = ifInstr[isaPkg::F3Lsb +: 3];
    assign funct7  = ifInstr[isaPkg::F7Lsb +: 7];
    assign aligned = (ifPc[1:0] == 2'b00);  // misaligned fetch is dropped

    // funct3 map shared by register and immediate forms
    always_comb begin
        f3Known = 1'b1;
        case (funct3)
            isaPkg::F3Add:  f3Op = pipePkg::AluAdd;
            isaPkg::F3Slt:  f3Op = pipePkg::AluSlt;
            isaPkg::F3Sltu: f3Op = pipePkg::AluSltu;
            isaPkg::F3Xor:  f3Op = pipePkg::AluXor;
            isaPkg::F3Or:   f3Op = pipePkg::AluOr;
            isaPkg::F3And:  f3Op = pipePkg::AluAnd;
            default: begin
                f3Op    = pipePkg::AluAdd;
                f3Known = 1'b0;  // shifts
            end
        endcase
    end

    // ----------------------------------------
    always_comb begin
        regWrite  = 1'b0;
        aluSrcImm = 1'b0;
        useRs1    = 1'b0;
        usePc     = 1'b0;
        isBranch  = 1'b0;
        isMul     = 1'b0;
        jalTaken  = 1'b0;
        aluOp     = pipePkg::AluAdd;
        imm       = '0;
        if (aligned) begin
            case (opcode)
                isaPkg::OpReg: begin
                    if (funct7 == isaPkg::F7MulDiv) begin
                        isMul    = (funct3 == isaPkg::F3Add);  // low half only
                        regWrite = isMul;
                        aluOp    = pipePkg::AluMul;
                    end else if (funct7 == isaPkg::F7Sub) begin
                        regWrite = (funct3 == isaPkg::F3Add);
                        aluOp    = pipePkg::AluSub;
                    end else begin
                        regWrite = (funct7 == 7'b0) && f3Known;
                        aluOp    = f3Op;
                    end
                    useRs1 = regWrite;
                end
                isaPkg::OpImm: begin
                    regWrite  = f3Known && funct3 != isaPkg::F3Slt && funct3 != isaPkg::F3Sltu;
                    useRs1    = regWrite;
                    aluSrcImm = 1'b1;
                    aluOp     = f3Op;
                    imm       = Xlen'($signed(ifInstr[31:20]));
                end
                isaPkg::OpLui: begin
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluOp     = pipePkg::AluPassB;
                    imm       = Xlen'($signed({ifInstr[31:12], 12'b0}));
                end
                isaPkg::OpAuipc: begin
                    regWrite  = 1'b1;
                    usePc     = 1'b1;
                    aluSrcImm = 1'b1;
                    imm       = Xlen'($signed({ifInstr[31:12], 12'b0}));
                end
                isaPkg::OpBranch: begin
                    isBranch = (funct3[2:1] != 2'b01);  // 010, 011 are reserved
                    useRs1   = 1'b1;
                    imm      = Xlen'($signed({ifInstr[31], ifInstr[7], ifInstr[30:25],
                                              ifInstr[11:8], 1'b0}));
                end
                isaPkg::OpJal: begin
                    regWrite = 1'b1;
                    jalTaken = 1'b1;
                    aluOp    = pipePkg::AluLink;
                    imm      = Xlen'($signed({ifInstr[31], ifInstr[19:12], ifInstr[20],
                                              ifInstr[30:21], 1'b0}));
                end
                default: ;  // unknown opcode, bubble
            endcase
        end
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile #(
    parameter int Xlen = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  isaPkg::regAddrT rs1,
    input  isaPkg::regAddrT rs2,
    output logic [Xlen-1:0] rdata1,
    output logic [Xlen-1:0] rdata2,
    input  logic            we,
    input  isaPkg::regAddrT rd,
    input  logic [Xlen-1:0] wdata
);

    logic [Xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;  // architectural state starts at zero
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // write-through, a producer two ahead is seen here
    assign rdata1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

//--- src/execStage.sv
`timescale 1ns/1ps

module execStage #(
    parameter int Xlen = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            hold,
    input  logic            regWrite,
    input  logic            aluSrcImm,
    input  logic            useRs1,
    input  logic            usePc,
    input  logic            isBranch,
    input  logic            isMul,
    input  pipePkg::aluOpT  aluOp,
    input  logic [Xlen-1:0] imm,
    input  logic [Xlen-1:0] ifPc,
    input  isaPkg::instrT   ifInstr,
    input  logic [Xlen-1:0] rdata1,
    input  logic [Xlen-1:0] rdata2,
    input  logic            mulStart,
    output logic            exeIsMul,
    output logic            mulDone,
    output logic            branchTaken,
    output logic [Xlen-1:0] branchTarget,
    output logic            commitValid,
    output logic [Xlen-1:0] commitPc,
    output isaPkg::instrT   commitInstr,
    output logic            commitWe,
    output isaPkg::regAddrT commitRd,
    output logic [Xlen-1:0] commitData
);

    logic            exeRegWrite;
    logic            exeIsBranch;
    logic            exeAluSrcImm;
    logic            exeUseRs1;
    logic            exeUsePc;
    pipePkg::aluOpT  exeAluOp;
    isaPkg::instrT   exeInstr;
    logic [Xlen-1:0] exePc;
    logic [Xlen-1:0] exeImm;
    logic [Xlen-1:0] exeRs1Data;
    logic [Xlen-1:0] exeRs2Data;
    logic [Xlen-1:0] rs1Val;
    logic [Xlen-1:0] rs2Val;
    logic [Xlen-1:0] opA;
    logic [Xlen-1:0] opB;
    logic [Xlen-1:0] aluResult;
    logic [Xlen-1:0] mulProduct;
    logic            equal;
    logic            sLess;
    logic            uLess;
    logic            condMet;
    logic            wbValid;

    // ---------------------------------------- IF -> EXE
    always_ff @(posedge clk) begin
        if (reset) begin
            exeRegWrite <= 1'b0;
            exeIsBranch <= 1'b0;
            exeIsMul    <= 1'b0;
            exeInstr    <= pipePkg::NopInstr;
        end else if (!hold) begin
            exeRegWrite <= regWrite;
            exeIsBranch <= isBranch;
            exeIsMul    <= isMul;
            exeInstr    <= ifInstr;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            exeAluSrcImm <= aluSrcImm;
            exeUseRs1    <= useRs1;
            exeUsePc     <= usePc;
            exeAluOp     <= aluOp;
            exePc        <= ifPc;
            exeImm       <= imm;
            exeRs1Data   <= rdata1;
            exeRs2Data   <= rdata2;
        end
    end

    // WB bypass, distance one
    assign rs1Val = (commitWe && commitRd == exeInstr[isaPkg::Rs1Lsb +: 5]) ? commitData : exeRs1Data;
    assign rs2Val = (commitWe && commitRd == exeInstr[isaPkg::Rs2Lsb +: 5]) ? commitData : exeRs2Data;

    assign opA = exeUsePc ? exePc : (exeUseRs1 ? rs1Val : '0);
    assign opB = exeAluSrcImm ? exeImm : rs2Val;

    assign equal = (opA == opB);
    assign sLess = ($signed(opA) < $signed(opB));
    assign uLess = (opA < opB);

    mulUnit #(
        .Xlen(Xlen)
    ) uMul (
        .clk    (clk),
        .reset  (reset),
        .start  (mulStart),
        .a      (opA),
        .b      (opB),
        .product(mulProduct),
        .done   (mulDone)
    );

    always_comb begin
        case (exeAluOp)
            pipePkg::AluAdd:   aluResult = opA + opB;
            pipePkg::AluSub:   aluResult = opA - opB;
            pipePkg::AluAnd:   aluResult = opA & opB;
            pipePkg::AluOr:    aluResult = opA | opB;
            pipePkg::AluXor:   aluResult = opA ^ opB;
            pipePkg::AluSlt:   aluResult = Xlen'(sLess);
            pipePkg::AluSltu:  aluResult = Xlen'(uLess);
            pipePkg::AluPassB: aluResult = opB;
            pipePkg::AluLink:  aluResult = exePc + Xlen'(pipePkg::InstrBytes);
            pipePkg::AluMul:   aluResult = mulProduct;
            default:           aluResult = '0;
        endcase
    end

    always_comb begin
        case (exeInstr[isaPkg::F3Lsb +: 3])
            isaPkg::F3Beq:  condMet = equal;
            isaPkg::F3Bne:  condMet = !equal;
            isaPkg::F3Blt:  condMet = sLess;
            isaPkg::F3Bge:  condMet = !sLess;
            isaPkg::F3Bltu: condMet = uLess;
            isaPkg::F3Bgeu: condMet = !uLess;
            default:        condMet = 1'b0;
        endcase
    end

    assign branchTaken  = exeIsBranch && condMet;
    assign branchTarget = exePc + exeImm;

    // ---------------------------------------- EXE -> WB
    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid     <= 1'b0;
            commitWe    <= 1'b0;
            commitInstr <= pipePkg::NopInstr;
        end else if (!hold) begin
            wbValid     <= exeRegWrite || exeIsBranch;
            commitWe    <= exeRegWrite && (exeInstr[isaPkg::RdLsb +: 5] != '0);  // x0 stays zero
            commitInstr <= exeInstr;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            commitPc   <= exePc;
            commitData <= aluResult;
        end
    end

    assign commitRd    = commitInstr[isaPkg::RdLsb +: 5];
    assign commitValid = wbValid && !hold;  // WB is frozen while held

endmodule

//--- src/stallFsm.sv
`timescale 1ns/1ps

module stallFsm (
    input  logic clk,
    input  logic reset,
    input  logic exeIsMul,
    input  logic mulDone,
    output logic mulStart,
    output logic hold
);

    typedef enum logic [1:0] {
        Idle,
        Busy,
        Drain
    } stateT;

    stateT state;
    stateT nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle:    if (exeIsMul) nextState = Busy;
            Busy:    if (mulDone) nextState = Drain;
            Drain:   nextState = Idle;  // product goes to WB
            default: nextState = Idle;
        endcase
    end

    // mul still sits in EXE during Drain, so no restart there
    assign mulStart = (state == Idle) && exeIsMul;
    assign hold     = mulStart || (state == Busy);

endmodule

//--- src/rvCore.sv
`timescale 1ns/1ps

module rvCore #(
    parameter int              Xlen   = 64,
    parameter logic [Xlen-1:0] PcInit = Xlen'('h8000_0000)
) (
    input  logic            clk,
    input  logic            reset,
    output logic [Xlen-1:0] fetchAddr,
    input  isaPkg::instrT   fetchData,
    input  logic            fetchOk,
    output logic            commitValid,
    output logic [Xlen-1:0] commitPc,
    output isaPkg::instrT   commitInstr,
    output logic            commitWe,
    output isaPkg::regAddrT commitRd,
    output logic [Xlen-1:0] commitData
);

    logic [Xlen-1:0] ifPc;
    isaPkg::instrT   ifInstr;
    logic            regWrite;
    logic            aluSrcImm;
    logic            useRs1;
    logic            usePc;
    logic            isBranch;
    logic            isMul;
    logic            jalTaken;
    pipePkg::aluOpT  aluOp;
    logic [Xlen-1:0] imm;
    logic [Xlen-1:0] rdata1;
    logic [Xlen-1:0] rdata2;
    logic            hold;
    logic            mulStart;
    logic            mulDone;
    logic            exeIsMul;
    logic            branchTaken;
    logic [Xlen-1:0] branchTarget;

    // ---------------------------------------- IF
    fetchUnit #(
        .Xlen  (Xlen),
        .PcInit(PcInit)
    ) uFetch (
        .clk         (clk),
        .reset       (reset),
        .fetchOk     (fetchOk),
        .fetchData   (fetchData),
        .hold        (hold),
        .jalTaken    (jalTaken),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .ifImm       (imm),
        .fetchAddr   (fetchAddr),
        .ifPc        (ifPc),
        .ifInstr     (ifInstr)
    );

    decoder #(
        .Xlen(Xlen)
    ) uDecoder (
        .ifInstr  (ifInstr),
        .ifPc     (ifPc),
        .regWrite (regWrite),
        .aluSrcImm(aluSrcImm),
        .useRs1   (useRs1),
        .usePc    (usePc),
        .isBranch (isBranch),
        .isMul    (isMul),
        .jalTaken (jalTaken),
        .aluOp    (aluOp),
        .imm      (imm)
    );

    regFile #(
        .Xlen(Xlen)
    ) uRegFile (
        .clk   (clk),
        .reset (reset),
        .rs1   (ifInstr[isaPkg::Rs1Lsb +: 5]),
        .rs2   (ifInstr[isaPkg::Rs2Lsb +: 5]),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .we    (commitWe),   // WB write
        .rd    (commitRd),
        .wdata (commitData)
    );

    // ---------------------------------------- EXE / WB
    execStage #(
        .Xlen(Xlen)
    ) uExec (
        .clk         (clk),
        .reset       (reset),
        .hold        (hold),
        .regWrite    (regWrite),
        .aluSrcImm   (aluSrcImm),
        .useRs1      (useRs1),
        .usePc       (usePc),
        .isBranch    (isBranch),
        .isMul       (isMul),
        .aluOp       (aluOp),
        .imm         (imm),
        .ifPc        (ifPc),
        .ifInstr     (ifInstr),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .mulStart    (mulStart),
        .exeIsMul    (exeIsMul),
        .mulDone     (mulDone),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .commitValid (commitValid),
        .commitPc    (commitPc),
        .commitInstr (commitInstr),
        .commitWe    (commitWe),
        .commitRd    (commitRd),
        .commitData  (commitData)
    );

    stallFsm uStall (
        .clk     (clk),
        .reset   (reset),
        .exeIsMul(exeIsMul),
        .mulDone (mulDone),
        .mulStart(mulStart),
        .hold    (hold)
    );

endmodule

//--- dv/coreTb.sv
`timescale 1ns/1ps

module coreTb;

    localparam int              Xlen      = 64;
    localparam logic [Xlen-1:0] MemBase   = 64'h8000_0000;
    localparam int              MemWords  = 64;
    localparam string           TraceFile = "dv/coreTrace.txt";

    logic            clk;
    logic            reset;
    logic [Xlen-1:0] fetchAddr;
    isaPkg::instrT   fetchData;
    logic            fetchOk;
    logic            commitValid;
    logic [Xlen-1:0] commitPc;
    isaPkg::instrT   commitInstr;
    logic            commitWe;
    isaPkg::regAddrT commitRd;
    logic [Xlen-1:0] commitData;

    isaPkg::instrT   mem [MemWords];
    logic [Xlen-1:0] expPc [$];
    int              expRd [$];
    logic [Xlen-1:0] expData [$];
    int              nExp   = 0;
    int              expIdx = 0;
    int              errors = 0;
    int              cycles = 0;
    int              limit  = 0;
    int              seed   = 32'ha6326598;

    rvCore #(
        .Xlen  (Xlen),
        .PcInit(MemBase)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .fetchAddr  (fetchAddr),
        .fetchData  (fetchData),
        .fetchOk    (fetchOk),
        .commitValid(commitValid),
        .commitPc   (commitPc),
        .commitInstr(commitInstr),
        .commitWe   (commitWe),
        .commitRd   (commitRd),
        .commitData (commitData)
    );

    // words that the trace does not set
    function automatic isaPkg::instrT fillWord(input logic [Xlen-1:0] addr);
        return addr[31:0] ^ addr[Xlen-1:32];
    endfunction

    function automatic isaPkg::instrT wordAt(input logic [Xlen-1:0] addr);
        logic [Xlen-1:0] offset;
        offset = addr - MemBase;
        if (offset[1:0] != 2'b00 || offset >= Xlen'(MemWords * 4)) begin
            return fillWord(addr);  // outside the program
        end
        return mem[offset[$clog2(MemWords)+1:2]];
    endfunction

    task automatic loadTrace();
        int              fd;
        int              c;
        int              n;
        int              rd;
        logic [Xlen-1:0] addr;
        logic [Xlen-1:0] offset;
        logic [Xlen-1:0] data;
        logic [31:0]     word;
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = fillWord(MemBase + Xlen'(i * 4));
        end
        fd = $fopen(TraceFile, "r");
        if (fd == 0) begin
            $display("cannot open trace file %s", TraceFile);
            errors++;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == int'("#")) begin
                while (c != -1 && c != 10) begin
                    c = $fgetc(fd);  // skip to end of line
                end
            end else if (c == int'("I")) begin
                n = $fscanf(fd, "%h %h", addr, word);
                offset = addr - MemBase;
                if (n != 2 || offset[1:0] != 2'b00 || offset >= Xlen'(MemWords * 4)) begin
                    $display("bad program line in trace near address %h", addr);
                    errors++;
                end else begin
                    mem[offset[$clog2(MemWords)+1:2]] = word;
                end
            end else if (c == int'("C")) begin
                n = $fscanf(fd, "%h %d %h", addr, rd, data);
                if (n != 3) begin
                    $display("bad commit line in trace after %0d entries", expPc.size());
                    errors++;
                end else begin
                    expPc.push_back(addr);
                    expRd.push_back(rd);
                    expData.push_back(data);
                end
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic reportMismatch(input string field, input logic [Xlen-1:0] got,
                                  input logic [Xlen-1:0] want);
        errors++;
        $display("** Error at time %0t: commit %0d at pc %h has %s %h, expected %h",
                 $time, expIdx, expPc[expIdx], field, got, want);
    endtask

    task automatic checkCommit();
        logic wantWe;
        wantWe = (expRd[expIdx] != 0);  // rd 0 in the trace means no write
        if (commitPc !== expPc[expIdx]) begin
            reportMismatch("pc", commitPc, expPc[expIdx]);
        end
        if (commitInstr !== wordAt(commitPc)) begin
            reportMismatch("instruction", Xlen'(commitInstr), Xlen'(wordAt(commitPc)));
        end
        if (commitWe !== wantWe) begin
            reportMismatch("write enable", Xlen'(commitWe), Xlen'(wantWe));
        end
        if (wantWe && commitRd !== isaPkg::regAddrT'(expRd[expIdx])) begin
            reportMismatch("rd", Xlen'(commitRd), Xlen'(expRd[expIdx]));
        end
        if (wantWe && commitData !== expData[expIdx]) begin
            reportMismatch("data", commitData, expData[expIdx]);
        end
        expIdx++;
    endtask

    // ----------------------------------------
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // memory answers a small delay after the edge
    always @(posedge clk) begin
        #1;
        fetchOk   = (($random(seed) & 3) != 0);  // low about one cycle in four
        fetchData = wordAt(fetchAddr);
    end

    always @(negedge clk) begin
        if (!reset && commitValid && expIdx < nExp) begin
            checkCommit();
        end
    end

    // ----------------------------------------
    initial begin
        reset     = 1'b1;
        fetchOk   = 1'b0;
        fetchData = '0;
        loadTrace();
        nExp = expPc.size();
        if (nExp == 0) begin
            $display("trace holds no expected commits");
            errors++;
        end
        limit = nExp * (Xlen + 12) + 200;  // worst case is every commit a mul
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        if (fetchAddr !== MemBase) begin
            errors++;
            $display("** Error at time %0t: fetchAddr %h after reset, expected %h",
                     $time, fetchAddr, MemBase);
        end
        if (commitValid !== 1'b0) begin
            errors++;
            $display("** Error at time %0t: commitValid %b after reset, expected 0",
                     $time, commitValid);
        end
        while (expIdx < nExp && cycles < limit) begin
            @(posedge clk);
        end
        if (expIdx < nExp) begin
            $display("timeout after %0d cycles, the program did not finish (%0d of %0d commits)",
                     cycles, expIdx, nExp);
            errors++;
        end
        $display("errors: %0d, commits checked: %0d of %0d", errors, expIdx, nExp);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- dv/coreTrace.txt
# I address word gives the program
# C pc rd data gives the expected commits in order (hex except rd, rd 0 means no write)
I 80000000 00500093
I 80000004 ffd08113
I 80000008 002081b3
I 8000000c 40310233
I 80000010 001222b3
I 80000014 00123333
I 80000018 0f024393
I 8000001c 1001e413
I 80000020 ff027493
I 80000024 0083f533
I 80000028 005565b3
I 8000002c 0085c633
I 80000030 123456b7
I 80000034 00001717
I 80000038 fffff7b7
I 8000003c 00700013
I 80000040 00100833
I 80000044 00208463
I 80000048 00a58463
I 8000004c 00100a13
I 80000050 00a59463
I 80000054 00209463
I 80000058 00200a13
I 8000005c 0040c463
I 80000060 00124463
I 80000064 00300a13
I 80000068 00125463
I 8000006c 0040d463
I 80000070 00400a13
I 80000074 00126463
I 80000078 0040e463
I 8000007c 00500a13
I 80000080 0040f463
I 80000084 00127463
I 80000088 00600a13
I 8000008c 00c00aef
I 80000090 00700a13
I 80000094 00800a13
I 80000098 02120b33
I 8000009c 001b0bb3
I 800000a0 024b0c33
I 800000a4 018c0cb3
I 800000a8 015a0d33
I 800000ac 0000006f
# alu chain, lui and auipc, write to x0
C 80000000 1 0000000000000005
C 80000004 2 0000000000000002
C 80000008 3 0000000000000007
C 8000000c 4 fffffffffffffffb
C 80000010 5 0000000000000001
C 80000014 6 0000000000000000
C 80000018 7 ffffffffffffff0b
C 8000001c 8 0000000000000107
C 80000020 9 fffffffffffffff0
C 80000024 10 0000000000000103
C 80000028 11 0000000000000103
C 8000002c 12 0000000000000004
C 80000030 13 0000000012345000
C 80000034 14 0000000080001034
C 80000038 15 fffffffffffff000
C 8000003c 0 0000000000000000
C 80000040 16 0000000000000005
# each branch not taken then taken
C 80000044 0 0000000000000000
C 80000048 0 0000000000000000
C 80000050 0 0000000000000000
C 80000054 0 0000000000000000
C 8000005c 0 0000000000000000
C 80000060 0 0000000000000000
C 80000068 0 0000000000000000
C 8000006c 0 0000000000000000
C 80000074 0 0000000000000000
C 80000078 0 0000000000000000
C 80000080 0 0000000000000000
C 80000084 0 0000000000000000
# jal, mul with dependents, x20 never written
C 8000008c 21 0000000080000090
C 80000098 22 ffffffffffffffe7
C 8000009c 23 ffffffffffffffec
C 800000a0 24 000000000000007d
C 800000a4 25 00000000000000fa
C 800000a8 26 0000000080000090
C 800000ac 0 0000000000000000

//--- project.f
src/isaPkg.sv
src/pipePkg.sv
src/mulUnit.sv
src/fetchUnit.sv
src/decoder.sv
src/regFile.sv
src/execStage.sv
src/stallFsm.sv
src/rvCore.sv
dv/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module coreTb -f project.f \
    --Mdir obj_dir -o coreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/coreSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "all tests passed" "$logFile"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
